/* hw/axi_pkg.sv */
package axi_pkg;

   // Burst type encoding on AxBURST
   typedef enum logic [1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01,
      BURST_WRAP  = 2'b10
   } axi_burst_e;

   // Response encoding on BRESP and RRESP
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_EXOKAY = 2'b01,
      RESP_SLVERR = 2'b10,
      RESP_DECERR = 2'b11
   } axi_resp_e;

   // Fixed part of AW and AR
   typedef struct packed {
      logic [7:0] len;
      logic [2:0] size;
      axi_burst_e burst;
   } axi_ax_ctrl_t;

   // Status fields of one R beat
   typedef struct packed {
      axi_resp_e resp;
      logic      last;
   } axi_r_ctrl_t;

endpackage

/* hw/dma_pkg.sv */
package dma_pkg;

   // Transfer direction as seen from memory
   typedef enum logic {
      DIR_READ  = 1'b0,
      DIR_WRITE = 1'b1
   } dma_dir_e;

   // Shared by both AXI engines
   typedef enum logic [1:0] {
      IDLE = 2'b00,
      ADDR = 2'b01,
      DATA = 2'b10,
      RESP = 2'b11
   } engine_state_e;

   // Native request, push when any strobe bit is set
   typedef struct packed {
      logic valid;
      logic push;
   } native_req_t;

endpackage

/* hw/sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo #(
   parameter int DATA_W = 32,
   parameter int LEN_W  = 4
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              w_en,
   input  logic [DATA_W-1:0] w_data,
   output logic              full,
   input  logic              r_en,
   output logic [DATA_W-1:0] r_data,
   output logic              empty,
   output logic [LEN_W:0]    level
);

   localparam int DEPTH = 1 << LEN_W;

   logic [DATA_W-1:0] mem [DEPTH];
   logic [LEN_W-1:0]  wr_ptr;
   logic [LEN_W-1:0]  rd_ptr;
   logic              do_wr;
   logic              do_rd;

   assign full  = level[LEN_W];
   assign empty = level == '0;
   assign do_wr = w_en && !full;
   assign do_rd = r_en && !empty;

   // Oldest entry always visible
   assign r_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= w_data;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leaves the count alone
         if (do_wr && !do_rd) begin
            level <= level + 1'b1;
         end else if (do_rd && !do_wr) begin
            level <= level - 1'b1;
         end
      end
   end

endmodule

/* hw/burst_planner.sv */
`timescale 1ns/1ns

module burst_planner import dma_pkg::*; #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32,
   parameter int LEN_W  = 4
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              run,
   input  dma_dir_e          dir,
   input  logic [ADDR_W-1:0] addr,
   input  logic [LEN_W:0]    in_level,
   input  logic [LEN_W:0]    out_level,
   input  logic              rd_idle,
   input  logic              wr_idle,
   output logic              ready,
   output logic              launch_rd,
   output logic              launch_wr,
   output logic [ADDR_W-1:0] burst_addr,
   output logic [7:0]        burst_len
);

   localparam int BYTE_W  = $clog2(DATA_W / 8);
   localparam int WADDR_W = ADDR_W - BYTE_W;
   localparam int PAGE_W  = 12 - BYTE_W;
   localparam logic [LEN_W:0] DEPTH = {1'b1, {LEN_W{1'b0}}};

   dma_dir_e           dir_q;
   logic               armed;
   logic [ADDR_W-1:0]  addr_q;
   logic [LEN_W-1:0]   count;
   logic [LEN_W:0]     avail;
   logic               launch;
   logic               idle;
   logic [WADDR_W-1:0] word_addr;
   logic [WADDR_W-1:0] page_end;
   logic [WADDR_W-1:0] avail_end;
   logic [WADDR_W-1:0] burst_end;
   logic [WADDR_W-1:0] next_word;

   // Words waiting to go out, or room for words to come in
   assign avail = (dir_q == DIR_WRITE) ? in_level : DEPTH - out_level;

   assign idle   = rd_idle && wr_idle;
   assign launch = armed && idle && (avail != '0) && (avail[LEN_W] || (&count));
   assign ready  = idle && !launch;

   assign launch_rd = launch && (dir_q == DIR_READ);
   assign launch_wr = launch && (dir_q == DIR_WRITE);

   // Burst stops at the last available word or the page end
   assign word_addr = addr_q[ADDR_W-1:BYTE_W];
   assign page_end  = {word_addr[WADDR_W-1:PAGE_W], {PAGE_W{1'b1}}};
   assign avail_end = word_addr + WADDR_W'(avail) - 1'b1;
   assign burst_end = (page_end < avail_end) ? page_end : avail_end;
   assign next_word = burst_end + 1'b1;

   assign burst_addr = addr_q;
   assign burst_len  = 8'(burst_end - word_addr);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         dir_q  <= DIR_READ;
         armed  <= 1'b0;
         addr_q <= '0;
      end else if (run && ready) begin
         dir_q  <= dir;
         armed  <= 1'b1;
         addr_q <= addr;
      end else if (launch) begin
         addr_q <= ADDR_W'(next_word) << BYTE_W;
      end
   end

   // Idle timeout, saturates at all ones
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count <= '0;
      end else if (launch || (run && ready)) begin
         count <= '0;
      end else if ((avail != '0) && !(&count)) begin
         count <= count + 1'b1;
      end
   end

endmodule

/* hw/axi_read_engine.sv */
`timescale 1ns/1ns

module axi_read_engine import axi_pkg::*, dma_pkg::*; #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              launch,
   input  logic [ADDR_W-1:0] burst_addr,
   input  logic [7:0]        burst_len,
   input  logic              fifo_full,
   input  logic              arready,
   input  logic [DATA_W-1:0] rdata,
   input  axi_resp_e         rresp,
   input  logic              rlast,
   input  logic              rvalid,
   output logic              idle,
   output logic              err,
   output logic [ADDR_W-1:0] araddr,
   output axi_ax_ctrl_t      ar_ctrl,
   output logic              arvalid,
   output logic              rready,
   output logic              fifo_wr,
   output logic [DATA_W-1:0] fifo_wdata
);

   engine_state_e     state;
   engine_state_e     state_nx;
   logic [ADDR_W-1:0] addr_q;
   logic [7:0]        len_q;
   axi_r_ctrl_t       r_ctrl;
   logic              r_hs;

   assign r_ctrl = '{resp: rresp, last: rlast};

   assign idle    = state == IDLE;
   assign arvalid = state == ADDR;
   assign araddr  = addr_q;
   assign ar_ctrl = '{len: len_q, size: 3'($clog2(DATA_W / 8)), burst: BURST_INCR};

   // Stall R while the output FIFO has no room
   assign rready     = (state == DATA) && !fifo_full;
   assign r_hs       = rvalid && rready;
   assign fifo_wr    = r_hs;
   assign fifo_wdata = rdata;
   assign err        = r_hs && (r_ctrl.resp != RESP_OKAY);

   always_comb begin
      state_nx = state;
      case (state)
         IDLE: begin
            if (launch) state_nx = ADDR;
         end
         ADDR: begin
            if (arready) state_nx = DATA;
         end
         DATA: begin
            if (r_hs && r_ctrl.last) state_nx = IDLE;
         end
         default: state_nx = IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= IDLE;
      end else begin
         state <= state_nx;
      end
   end

   always_ff @(posedge clk) begin
      if (launch && idle) begin
         addr_q <= burst_addr;
         len_q  <= burst_len;
      end
   end

endmodule

/* hw/axi_write_engine.sv */
`timescale 1ns/1ns

module axi_write_engine import axi_pkg::*, dma_pkg::*; #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       launch,
   input  logic [ADDR_W-1:0]          burst_addr,
   input  logic [7:0]                 burst_len,
   input  logic                       fifo_empty,
   input  logic [DATA_W+DATA_W/8-1:0] fifo_rdata,
   input  logic                       awready,
   input  logic                       wready,
   input  axi_resp_e                  bresp,
   input  logic                       bvalid,
   output logic                       idle,
   output logic                       err,
   output logic [ADDR_W-1:0]          awaddr,
   output axi_ax_ctrl_t               aw_ctrl,
   output logic                       awvalid,
   output logic [DATA_W-1:0]          wdata,
   output logic [DATA_W/8-1:0]        wstrb,
   output logic                       wlast,
   output logic                       wvalid,
   output logic                       bready,
   output logic                       fifo_rd
);

   engine_state_e     state;
   engine_state_e     state_nx;
   logic [ADDR_W-1:0] addr_q;
   logic [7:0]        len_q;
   logic [7:0]        beat;
   logic              w_hs;

   assign idle    = state == IDLE;
   assign awvalid = state == ADDR;
   assign awaddr  = addr_q;
   assign aw_ctrl = '{len: len_q, size: 3'($clog2(DATA_W / 8)), burst: BURST_INCR};

   // FIFO entry holds data above strobe
   assign wdata   = fifo_rdata[DATA_W/8 +: DATA_W];
   assign wstrb   = fifo_rdata[0 +: DATA_W/8];
   assign wvalid  = (state == DATA) && !fifo_empty;
   assign wlast   = beat == len_q;
   assign w_hs    = wvalid && wready;
   assign fifo_rd = w_hs;

   assign bready = state == RESP;
   assign err    = bvalid && bready && (bresp != RESP_OKAY);

   always_comb begin
      state_nx = state;
      case (state)
         IDLE: begin
            if (launch) state_nx = ADDR;
         end
         ADDR: begin
            if (awready) state_nx = DATA;
         end
         DATA: begin
            if (w_hs && wlast) state_nx = RESP;
         end
         RESP: begin
            if (bvalid) state_nx = IDLE;
         end
         default: state_nx = IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= IDLE;
         beat  <= '0;
      end else begin
         state <= state_nx;
         if (launch && idle) begin
            beat <= '0;
         end else if (w_hs) begin
            beat <= beat + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (launch && idle) begin
         addr_q <= burst_addr;
         len_q  <= burst_len;
      end
   end

endmodule

/* hw/stream_axi_dma.sv */
`timescale 1ns/1ns

module stream_axi_dma import axi_pkg::*, dma_pkg::*; #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32,
   parameter int LEN_W  = 4
) (
   input  logic                clk,
   input  logic                rst,
   // Control
   input  logic                run,
   input  dma_dir_e            dir,
   input  logic [ADDR_W-1:0]   addr,
   output logic                ready,
   output logic                error,
   // Native port
   input  logic                s_valid,
   input  logic [ADDR_W-1:0]   s_addr,
   input  logic [DATA_W-1:0]   s_wdata,
   input  logic [DATA_W/8-1:0] s_wstrb,
   output logic [DATA_W-1:0]   s_rdata,
   output logic                s_ready,
   // AXI4 master
   output logic [ADDR_W-1:0]   awaddr,
   output axi_ax_ctrl_t        aw_ctrl,
   output logic                awvalid,
   input  logic                awready,
   output logic [DATA_W-1:0]   wdata,
   output logic [DATA_W/8-1:0] wstrb,
   output logic                wlast,
   output logic                wvalid,
   input  logic                wready,
   input  axi_resp_e           bresp,
   input  logic                bvalid,
   output logic                bready,
   output logic [ADDR_W-1:0]   araddr,
   output axi_ax_ctrl_t        ar_ctrl,
   output logic                arvalid,
   input  logic                arready,
   input  logic [DATA_W-1:0]   rdata,
   input  axi_resp_e           rresp,
   input  logic                rlast,
   input  logic                rvalid,
   output logic                rready
);

   localparam int IN_W = DATA_W + DATA_W / 8;

   native_req_t       req;
   native_req_t       req_q;
   logic              in_wr;
   logic              in_rd;
   logic              in_full;
   logic              in_empty;
   logic [IN_W-1:0]   in_rdata;
   logic [LEN_W:0]    in_level;
   logic              out_wr;
   logic              out_rd;
   logic              out_full;
   logic              out_empty;
   logic [DATA_W-1:0] out_wdata;
   logic [DATA_W-1:0] out_rdata_w;
   logic [LEN_W:0]    out_level;
   logic              launch_rd;
   logic              launch_wr;
   logic [ADDR_W-1:0] burst_addr;
   logic [7:0]        burst_len;
   logic              rd_idle;
   logic              wr_idle;
   logic              rd_err;
   logic              wr_err;

   // s_addr carries no information for a stream
   assign req = '{valid: s_valid, push: |s_wstrb};

   // Ready only from the second cycle of the same request
   assign s_ready = req.valid && req_q.valid && (req.push == req_q.push)
                    && (req.push ? !in_full : !out_empty);
   assign in_wr   = s_ready && req.push;
   assign out_rd  = s_ready && !req.push;
   assign s_rdata = out_rdata_w;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         req_q <= '0;
         error <= 1'b0;
      end else begin
         req_q <= req;
         if (run && ready) begin
            error <= 1'b0;
         end else if (rd_err || wr_err) begin
            error <= 1'b1;
         end
      end
   end

   sync_fifo #(.DATA_W(IN_W), .LEN_W(LEN_W)) in_fifo (
      .clk    (clk),
      .rst    (rst),
      .w_en   (in_wr),
      .w_data ({s_wdata, s_wstrb}),
      .full   (in_full),
      .r_en   (in_rd),
      .r_data (in_rdata),
      .empty  (in_empty),
      .level  (in_level)
   );

   sync_fifo #(.DATA_W(DATA_W), .LEN_W(LEN_W)) out_fifo (
      .clk    (clk),
      .rst    (rst),
      .w_en   (out_wr),
      .w_data (out_wdata),
      .full   (out_full),
      .r_en   (out_rd),
      .r_data (out_rdata_w),
      .empty  (out_empty),
      .level  (out_level)
   );

   burst_planner #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .LEN_W(LEN_W)) planner (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .dir        (dir),
      .addr       (addr),
      .in_level   (in_level),
      .out_level  (out_level),
      .rd_idle    (rd_idle),
      .wr_idle    (wr_idle),
      .ready      (ready),
      .launch_rd  (launch_rd),
      .launch_wr  (launch_wr),
      .burst_addr (burst_addr),
      .burst_len  (burst_len)
   );

   axi_read_engine #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) rd_engine (
      .clk        (clk),
      .rst        (rst),
      .launch     (launch_rd),
      .burst_addr (burst_addr),
      .burst_len  (burst_len),
      .fifo_full  (out_full),
      .arready    (arready),
      .rdata      (rdata),
      .rresp      (rresp),
      .rlast      (rlast),
      .rvalid     (rvalid),
      .idle       (rd_idle),
      .err        (rd_err),
      .araddr     (araddr),
      .ar_ctrl    (ar_ctrl),
      .arvalid    (arvalid),
      .rready     (rready),
      .fifo_wr    (out_wr),
      .fifo_wdata (out_wdata)
   );

   axi_write_engine #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) wr_engine (
      .clk        (clk),
      .rst        (rst),
      .launch     (launch_wr),
      .burst_addr (burst_addr),
      .burst_len  (burst_len),
      .fifo_empty (in_empty),
      .fifo_rdata (in_rdata),
      .awready    (awready),
      .wready     (wready),
      .bresp      (bresp),
      .bvalid     (bvalid),
      .idle       (wr_idle),
      .err        (wr_err),
      .awaddr     (awaddr),
      .aw_ctrl    (aw_ctrl),
      .awvalid    (awvalid),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .wlast      (wlast),
      .wvalid     (wvalid),
      .bready     (bready),
      .fifo_rd    (in_rd)
   );

endmodule

/* bench/axi_mem_model.sv */
`timescale 1ns/1ns

module axi_mem_model import axi_pkg::*; #(
   parameter logic [31:0] ERR_ADDR = 32'h0000_3800,
   parameter logic [31:0] SEED     = 32'hc3db7181
) (
   input  logic         clk,
   input  logic         rst,
   input  logic         stall_en,
   input  logic [31:0]  awaddr,
   input  axi_ax_ctrl_t aw_ctrl,
   input  logic         awvalid,
   output logic         awready,
   input  logic [31:0]  wdata,
   input  logic [3:0]   wstrb,
   input  logic         wlast,
   input  logic         wvalid,
   output logic         wready,
   output axi_resp_e    bresp,
   output logic         bvalid,
   input  logic         bready,
   input  logic [31:0]  araddr,
   input  axi_ax_ctrl_t ar_ctrl,
   input  logic         arvalid,
   output logic         arready,
   output logic [31:0]  rdata,
   output axi_resp_e    rresp,
   output logic         rlast,
   output logic         rvalid,
   input  logic         rready
);

   logic [31:0] mem [4096];
   integer      seed;
   logic [31:0] rnd;
   logic        go_aw;
   logic        go_w;
   logic        go_ar;
   logic        go_r;
   logic        w_busy;
   logic [11:0] w_idx;
   logic        w_err;
   logic        r_busy;
   logic [11:0] r_idx;
   logic [8:0]  r_cnt;
   logic [7:0]  r_len;
   logic        r_err;

   // Preload pattern, a function of the whole word address
   function automatic logic [31:0] fill_word(input int idx);
      return (32'(idx) * 32'h9e37_79b1) ^ {20'h5a5a5, 12'(idx)};
   endfunction

   initial begin
      seed = SEED;
      for (int i = 0; i < 4096; i++) begin
         mem[i] = fill_word(i);
      end
   end

   // Roughly one stall in four per channel
   always @(posedge clk) begin
      rnd <= stall_en ? $random(seed) : 32'hffff_ffff;
   end

   assign go_aw = |rnd[1:0];
   assign go_w  = |rnd[3:2];
   assign go_ar = |rnd[5:4];
   assign go_r  = |rnd[7:6];

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         bresp   <= RESP_OKAY;
         w_busy  <= 1'b0;
         w_idx   <= '0;
         w_err   <= 1'b0;
      end else begin
         awready <= 1'b0;
         wready  <= 1'b0;
         if (bvalid) begin
            if (bready) begin
               bvalid <= 1'b0;
               w_busy <= 1'b0;
            end
         end else if (!w_busy) begin
            if (awvalid && awready) begin
               w_busy <= 1'b1;
               w_idx  <= awaddr[13:2];
               w_err  <= awaddr == ERR_ADDR;
            end else begin
               awready <= go_aw;
            end
         end else if (wvalid && wready) begin
            for (int b = 0; b < 4; b++) begin
               if (wstrb[b]) begin
                  mem[w_idx][8*b +: 8] <= wdata[8*b +: 8];
               end
            end
            w_idx <= w_idx + 1'b1;
            if (wlast) begin
               bvalid <= 1'b1;
               bresp  <= w_err ? RESP_SLVERR : RESP_OKAY;
            end else begin
               wready <= go_w;
            end
         end else begin
            wready <= go_w;
         end
      end
   end

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
         rlast   <= 1'b0;
         rdata   <= '0;
         rresp   <= RESP_OKAY;
         r_busy  <= 1'b0;
         r_idx   <= '0;
         r_cnt   <= '0;
         r_len   <= '0;
         r_err   <= 1'b0;
      end else begin
         arready <= 1'b0;
         if (!r_busy) begin
            if (arvalid && arready) begin
               r_busy <= 1'b1;
               r_idx  <= araddr[13:2];
               r_len  <= ar_ctrl.len;
               r_cnt  <= '0;
               r_err  <= araddr == ERR_ADDR;
            end else begin
               arready <= go_ar;
            end
         end else if (rvalid && rready && rlast) begin
            rvalid <= 1'b0;
            r_busy <= 1'b0;
         end else if (!rvalid || rready) begin
            if (go_r && (r_cnt <= {1'b0, r_len})) begin
               rvalid <= 1'b1;
               rdata  <= mem[r_idx];
               rresp  <= r_err ? RESP_SLVERR : RESP_OKAY;
               rlast  <= r_cnt == {1'b0, r_len};
               r_idx  <= r_idx + 1'b1;
               r_cnt  <= r_cnt + 1'b1;
            end else begin
               rvalid <= 1'b0;
            end
         end
      end
   end

endmodule

/* bench/tb_stream_axi_dma.sv */
`timescale 1ns/1ns

module tb_stream_axi_dma import axi_pkg::*, dma_pkg::*;;

   localparam int ADDR_W  = 32;
   localparam int DATA_W  = 32;
   localparam int LEN_W   = 4;
   localparam int MAX_LEN = (1 << LEN_W) - 1;
   localparam int TIMEOUT = 4000;

   logic         clk;
   logic         rst;
   logic         run;
   dma_dir_e     dir;
   logic [31:0]  addr;
   logic         ready;
   logic         error;
   logic         s_valid;
   logic [31:0]  s_addr;
   logic [31:0]  s_wdata;
   logic [3:0]   s_wstrb;
   logic [31:0]  s_rdata;
   logic         s_ready;
   logic [31:0]  awaddr;
   axi_ax_ctrl_t aw_ctrl;
   logic         awvalid;
   logic         awready;
   logic [31:0]  wdata;
   logic [3:0]   wstrb;
   logic         wlast;
   logic         wvalid;
   logic         wready;
   axi_resp_e    bresp;
   logic         bvalid;
   logic         bready;
   logic [31:0]  araddr;
   axi_ax_ctrl_t ar_ctrl;
   logic         arvalid;
   logic         arready;
   logic [31:0]  rdata;
   axi_resp_e    rresp;
   logic         rlast;
   logic         rvalid;
   logic         rready;
   logic         stall_en;

   integer       seed;
   logic [31:0]  ref_mem [4096];
   logic [31:0]  w_expect [$];
   logic [31:0]  exp_w;
   logic [11:0]  cursor;
   int           aw_count;
   logic [7:0]   last_aw_len;
   logic [7:0]   w_len;
   int           w_beat;
   logic         split_seen;
   int           n0;

   stream_axi_dma #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .LEN_W(LEN_W)) stream_axi_dma_inst (
      .clk(clk), .rst(rst), .run(run), .dir(dir), .addr(addr), .ready(ready), .error(error),
      .s_valid(s_valid), .s_addr(s_addr), .s_wdata(s_wdata), .s_wstrb(s_wstrb),
      .s_rdata(s_rdata), .s_ready(s_ready),
      .awaddr(awaddr), .aw_ctrl(aw_ctrl), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .ar_ctrl(ar_ctrl), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready)
   );

   axi_mem_model #(.ERR_ADDR(32'h0000_3800), .SEED(32'hc3db7181)) mem_model_inst (
      .clk(clk), .rst(rst), .stall_en(stall_en),
      .awaddr(awaddr), .aw_ctrl(aw_ctrl), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .ar_ctrl(ar_ctrl), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Same preload rule as the memory holds after power up
   function automatic logic [31:0] expected_fill(input int idx);
      return (32'(idx) * 32'h9e37_79b1) ^ {20'h5a5a5, 12'(idx)};
   endfunction

   task automatic report_failure(input string line);
      $display("%s", line);
      $display("** FAIL **");
      $fatal(1);
   endtask

   task automatic check_page(input logic [31:0] a, input axi_ax_ctrl_t ctrl, input string ch);
      logic [12:0] end_off;
      end_off = {1'b0, a[11:0]} + {3'b000, ctrl.len, 2'b00} + 13'd4;
      assert (end_off <= 13'h1000)
         else report_failure($sformatf("%s burst at %h len %h crosses 4 KB",
                                       ch, a, ctrl.len));
      assert (ctrl.len <= 8'(MAX_LEN))
         else report_failure($sformatf("Mismatch %s len: got %h limit %h",
                                       ch, ctrl.len, MAX_LEN));
      // Four byte beats on a 32 bit bus
      assert (ctrl.size == 3'd2)
         else report_failure($sformatf("Mismatch %s size: got %h expected %h",
                                       ch, ctrl.size, 3'd2));
      assert (ctrl.burst == BURST_INCR)
         else report_failure($sformatf("Mismatch %s burst: got %h expected %h",
                                       ch, ctrl.burst, BURST_INCR));
      if (end_off == 13'h1000) begin
         split_seen = 1'b1;
      end
   endtask

   // Bus monitors sample at the falling edge
   always @(negedge clk) begin
      if (!rst && wvalid && wready) begin
         assert (w_expect.size() != 0)
            else report_failure("W beat arrived with no pushed word outstanding");
         exp_w = w_expect.pop_front();
         assert (wdata == exp_w)
            else report_failure($sformatf("Mismatch wdata: got %h expected %h", wdata, exp_w));
         assert (wstrb == 4'hf)
            else report_failure($sformatf("Mismatch wstrb: got %h expected %h", wstrb, 4'hf));
         // Beat number len closes the burst
         assert (wlast == (w_beat == int'(w_len)))
            else report_failure($sformatf("Mismatch wlast: got %h expected %h",
                                          wlast, w_beat == int'(w_len)));
         w_beat++;
      end
      if (!rst && awvalid && awready) begin
         check_page(awaddr, aw_ctrl, "AW");
         aw_count++;
         last_aw_len = aw_ctrl.len;
         w_len       = aw_ctrl.len;
         w_beat      = 0;
      end
      if (!rst && arvalid && arready) begin
         check_page(araddr, ar_ctrl, "AR");
      end
   end

   task automatic start_run(input dma_dir_e d, input logic [31:0] a);
      int t;
      t = 0;
      @(posedge clk);
      run  <= 1'b1;
      dir  <= d;
      addr <= a;
      @(negedge clk);
      while (!ready) begin
         t++;
         if (t > TIMEOUT) report_failure("Timed out waiting for ready to accept run");
         @(negedge clk);
      end
      @(posedge clk);
      run    <= 1'b0;
      cursor = a[13:2];
   endtask

   task automatic push_words(input int n);
      int t;
      logic [31:0] data;
      @(posedge clk);
      for (int k = 0; k < n; k++) begin
         data = $random(seed);
         s_valid <= 1'b1;
         s_wdata <= data;
         s_wstrb <= 4'hf;
         t = 0;
         @(negedge clk);
         while (!s_ready) begin
            t++;
            if (t > TIMEOUT) report_failure("Timed out waiting for s_ready on a push");
            @(negedge clk);
         end
         @(posedge clk);
         w_expect.push_back(data);
         ref_mem[cursor] = data;
         cursor++;
      end
      s_valid <= 1'b0;
      s_wstrb <= 4'h0;
   endtask

   task automatic pop_words(input int n);
      int t;
      logic [31:0] got;
      logic [31:0] rnd;
      @(posedge clk);
      for (int k = 0; k < n; k++) begin
         s_valid <= 1'b1;
         s_wstrb <= 4'h0;
         t = 0;
         @(negedge clk);
         while (!s_ready) begin
            t++;
            if (t > TIMEOUT) report_failure("Timed out waiting for s_ready on a pop");
            @(negedge clk);
         end
         got = s_rdata;
         assert (got == ref_mem[cursor])
            else report_failure($sformatf("Mismatch s_rdata: got %h expected %h",
                                          got, ref_mem[cursor]));
         @(posedge clk);
         cursor++;
         rnd = $random(seed);
         if (rnd[2]) begin
            s_valid <= 1'b0;
            repeat (rnd[1:0] + 1) @(posedge clk);
         end
      end
      s_valid <= 1'b0;
   endtask

   // All pushed words written and both engines back to idle
   task automatic wait_drained();
      int t;
      t = 0;
      @(negedge clk);
      while (w_expect.size() != 0 || !ready) begin
         t++;
         if (t > TIMEOUT) report_failure("Timed out waiting for the write stream to drain");
         @(negedge clk);
      end
   endtask

   task automatic compare_memory();
      for (int i = 0; i < 4096; i++) begin
         assert (mem_model_inst.mem[i] == ref_mem[i])
            else report_failure($sformatf("Mismatch mem[%h]: got %h expected %h",
                                          i, mem_model_inst.mem[i], ref_mem[i]));
      end
   endtask

   task automatic check_bit(input logic got, input logic expect_v, input string name);
      assert (got == expect_v)
         else report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, expect_v));
   endtask

   initial begin
      int t;
      seed        = 32'hc3db7181;
      rst         = 1'b1;
      run         = 1'b0;
      dir         = DIR_READ;
      addr        = '0;
      s_valid     = 1'b0;
      s_addr      = '0;
      s_wdata     = '0;
      s_wstrb     = '0;
      stall_en    = 1'b1;
      cursor      = '0;
      aw_count    = 0;
      last_aw_len = '0;
      w_len       = '0;
      w_beat      = 0;
      split_seen  = 1'b0;
      for (int i = 0; i < 4096; i++) begin
         ref_mem[i] = expected_fill(i);
      end
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_bit(ready, 1'b1, "ready");
      check_bit(error, 1'b0, "error");
      check_bit(s_ready, 1'b0, "s_ready");
      check_bit(awvalid, 1'b0, "awvalid");
      check_bit(wvalid, 1'b0, "wvalid");
      check_bit(arvalid, 1'b0, "arvalid");
      check_bit(bready, 1'b0, "bready");
      check_bit(rready, 1'b0, "rready");

      // Write stream across 0x1000 with stalls, then again without
      start_run(DIR_WRITE, 32'h0000_0F80);
      push_words(40);
      wait_drained();
      compare_memory();
      assert (split_seen) else report_failure("No write burst ended at a 4 KB boundary");
      stall_en   <= 1'b0;
      split_seen = 1'b0;
      start_run(DIR_WRITE, 32'h0000_2F80);
      push_words(40);
      wait_drained();
      compare_memory();
      assert (split_seen) else report_failure("No stall-free burst ended at a 4 KB boundary");
      stall_en <= 1'b1;

      // Partial burst after the idle timeout
      start_run(DIR_WRITE, 32'h0000_0400);
      n0 = aw_count;
      push_words(3);
      wait_drained();
      assert (aw_count == n0 + 1)
         else report_failure($sformatf("Mismatch aw_count: got %h expected %h",
                                       aw_count, n0 + 1));
      assert (last_aw_len == 8'd2)
         else report_failure($sformatf("Mismatch aw_ctrl.len: got %h expected %h",
                                       last_aw_len, 8'd2));
      compare_memory();

      // Read stream over a page boundary, first burst cut short by it
      split_seen = 1'b0;
      start_run(DIR_READ, 32'h0000_1FD0);
      pop_words(40);
      assert (split_seen) else report_failure("No read burst ended at a 4 KB boundary");

      // Error response is sticky until the next run
      start_run(DIR_WRITE, 32'h0000_3800);
      push_words(1);
      t = 0;
      @(negedge clk);
      while (!error) begin
         t++;
         if (t > TIMEOUT) report_failure("Timed out waiting for error after SLVERR");
         @(negedge clk);
      end
      wait_drained();
      repeat (20) begin
         @(negedge clk);
         check_bit(error, 1'b1, "error");
      end
      start_run(DIR_WRITE, 32'h0000_0000);
      @(negedge clk);
      check_bit(error, 1'b0, "error");

      $display("** PASS **");
      $finish;
   end

endmodule

/* vlog.f */
hw/axi_pkg.sv
hw/dma_pkg.sv
hw/sync_fifo.sv
hw/burst_planner.sv
hw/axi_read_engine.sv
hw/axi_write_engine.sv
hw/stream_axi_dma.sv
bench/axi_mem_model.sv
bench/tb_stream_axi_dma.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module tb_stream_axi_dma -o sim
./obj_dir/sim
